// File: sim.f
+incdir+common
common/player_pkg.sv
common/axil_pkg.sv
logic/button_press_unit.sv
player/song_reader.sv
player/note_gen.sv
player/player_regs.sv
logic/music_player_top.sv
test/tb_clock.sv
test/tb_music_player.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_music_player \
    -o tb_music_player > build.log 2>&1 &&
    ./obj_dir/tb_music_player > sim.log 2>&1 &&
    ! grep -q "TB FAILED" sim.log &&
    echo "simulation passed" ||
    { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: test/tb_music_player.sv
`timescale 1ns/1ps
`default_nettype none

`include "player_params.svh"

module tb_music_player;
    import player_pkg::*;
    import axil_pkg::*;

    localparam int OP_WRITE = 0;
    localparam int OP_READ  = 1;
    localparam int OP_PRESS = 2;
    localparam int OP_SONG  = 3;
    localparam int OP_NEXT  = 4;

    logic       clk_100;
    logic       rst_n;
    logic       play_button;
    logic       next_button;
    logic       new_frame;
    axil_addr_t axil_awaddr;
    logic       axil_awvalid;
    logic       axil_awready;
    axil_data_t axil_wdata;
    axil_strb_t axil_wstrb;
    logic       axil_wvalid;
    logic       axil_wready;
    axil_resp_t axil_bresp;
    logic       axil_bvalid;
    logic       axil_bready;
    axil_addr_t axil_araddr;
    logic       axil_arvalid;
    logic       axil_arready;
    axil_data_t axil_rdata;
    axil_resp_t axil_rresp;
    logic       axil_rvalid;
    logic       axil_rready;
    sample_t    sample;
    logic       new_sample;
    logic       playing;
    note_t      note;

    // Reference copy of the two songs
    int song_notes [2][8] = '{'{20, 22, 24, 0, 25, 27, 29, 32},
                              '{40, 37, 0, 35, 33, 30, 28, 25}};
    string op_names [5] = '{"write", "read", "press", "song", "next"};

    // Stimulus table, one entry per test
    int         step_op [$];
    axil_addr_t step_addr [$];
    axil_data_t step_data [$];
    axil_strb_t step_strb [$];
    axil_data_t step_exp [$];
    logic [1:0] step_resp [$];

    int          err_count = 0;
    int          tests_pass = 0;
    int          tests_fail = 0;
    int          cycles = 0;
    int          limit = 0;
    logic [31:0] lfsr = 32'h889d;

    // Sample model state
    logic [`PHASE_W-1:0] model_phase;
    logic [`PHASE_W-1:0] model_base;
    logic [`PHASE_W-1:0] model_step;
    note_t               model_prev;
    sample_t             exp_sample;
    logic                exp_new;
    weight_t             model_weight;

    tb_clock #(.PERIOD_NS(8.0)) clock_gen (.clk(clk_100));

    music_player_top #(.BPU_WIDTH(2)) UUT (.*);

    // ==================================================
    // Helpers
    // ==================================================
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            err_count++;
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // Square wave level from note, phase sign and weight
    function automatic sample_t square_level(input note_t n, input logic msb, input weight_t w);
        sample_t amp;
        amp = sample_t'(16'h0FFF << w);
        if (n == '0)
            return '0;
        return msb ? -amp : amp;
    endfunction

    task automatic add_step(input int op, input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input axil_data_t exp,
                            input logic [1:0] resp);
        step_op.push_back(op);
        step_addr.push_back(addr);
        step_data.push_back(data);
        step_strb.push_back(strb);
        step_exp.push_back(exp);
        step_resp.push_back(resp);
    endtask

    // Rough cycle cost of one table entry
    function automatic int step_budget(input int op, input axil_data_t data);
        case (op)
            OP_PRESS: return int'(data) + 20;
            OP_SONG:  return `SONG_LEN * int'(data) + 30;
            OP_NEXT:  return 3 * int'(data) + 40;
            default:  return 12;
        endcase
    endfunction

    // ==================================================
    // Bus and button drivers
    // ==================================================
    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb, output logic [1:0] resp);
        logic aw_left;
        logic w_left;
        logic aw_go;
        logic w_go;
        @(posedge clk_100);
        #1;
        axil_awaddr  = addr;
        axil_awvalid = 1'b1;
        axil_wdata   = data;
        axil_wstrb   = strb;
        axil_wvalid  = 1'b1;
        axil_bready  = 1'b1;
        aw_left = 1'b1;
        w_left  = 1'b1;
        // Each channel drops valid after its own handshake
        while (aw_left || w_left) begin
            aw_go = aw_left && axil_awready;
            w_go  = w_left && axil_wready;
            @(posedge clk_100);
            #1;
            if (aw_go) begin
                axil_awvalid = 1'b0;
                aw_left = 1'b0;
            end
            if (w_go) begin
                axil_wvalid = 1'b0;
                w_left = 1'b0;
            end
        end
        // Weight register commits on the last handshake edge
        if (addr == REG_CTRL && strb[0])
            model_weight = data[1:0];
        while (!axil_bvalid) begin
            @(posedge clk_100);
            #1;
        end
        resp = axil_bresp;
        @(posedge clk_100);
        #1;
        axil_bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output logic [1:0] resp);
        @(posedge clk_100);
        #1;
        axil_araddr  = addr;
        axil_arvalid = 1'b1;
        axil_rready  = 1'b1;
        while (!axil_arready) begin
            @(posedge clk_100);
            #1;
        end
        @(posedge clk_100);
        #1;
        axil_arvalid = 1'b0;
        while (!axil_rvalid) begin
            @(posedge clk_100);
            #1;
        end
        data = axil_rdata;
        resp = axil_rresp;
        @(posedge clk_100);
        #1;
        axil_rready = 1'b0;
    endtask

    // Button high for hold cycles, 0 is play and 1 is next
    task automatic press(input int which, input int hold);
        @(posedge clk_100);
        #1;
        if (which == 0)
            play_button = 1'b1;
        else
            next_button = 1'b1;
        repeat (hold) @(posedge clk_100);
        #1;
        play_button = 1'b0;
        next_button = 1'b0;
    endtask

    // Start playback and follow every note of the song
    task automatic follow_song(input int s, input int beat);
        note_t cur;
        int    len;
        press(0, 5);
        while (!playing) @(negedge clk_100);
        for (int n = 0; n < `SONG_LEN; n++) begin
            cur = note;
            check_value("note", 32'(cur), song_notes[s][n]);
            len = 0;
            while (note == cur && len <= beat) begin
                len++;
                @(negedge clk_100);
            end
            check_value("note_cycles", len, beat);
        end
        check_value("playing", 32'(playing), 0);
    endtask

    // Next pressed two notes into playback
    task automatic next_during_play(input int beat);
        int wait_cycles;
        press(0, 5);
        while (!playing) @(negedge clk_100);
        repeat (2 * beat) @(negedge clk_100);
        check_value("playing", 32'(playing), 1);
        press(1, 5);
        wait_cycles = 0;
        // Stop follows the debounced pulse, long before the song ends
        while (playing && wait_cycles < 8) begin
            wait_cycles++;
            @(negedge clk_100);
        end
        check_value("playing", 32'(playing), 0);
        check_value("note", 32'(note), 0);
    endtask

    // ==================================================
    // Frame strobes and sample checker
    // ==================================================
    initial begin
        int gap;
        new_frame = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            // Gap of 2 to 9 cycles
            take_bits(3, gap);
            repeat (gap + 1) @(posedge clk_100);
            #1 new_frame = 1'b1;
            @(posedge clk_100);
            #1 new_frame = 1'b0;
        end
    end

    always @(negedge clk_100) begin
        if (rst_n !== 1'b1) begin
            model_phase = '0;
            model_prev  = '0;
            exp_sample  = '0;
            exp_new     = 1'b0;
        end else begin
            // One sample strobe on the cycle after each frame strobe
            check_value("new_sample", 32'(new_sample), 32'(exp_new));
            if (new_sample)
                check_value("sample", 32'(sample), 32'(exp_sample));
            // Waveform restarts on a new note
            model_base = (note != model_prev) ? '0 : model_phase;
            model_step = model_base + (`PHASE_W'(note) << 6);
            if (new_frame) begin
                model_phase = model_step;
                exp_sample  = square_level(note, model_step[`PHASE_W-1], model_weight);
            end else begin
                model_phase = model_base;
            end
            model_prev = note;
            exp_new    = new_frame;
        end
    end

    always @(posedge clk_100) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Simulation timed out after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int         errs_before;
        int         total;
        axil_data_t rdata;
        logic [1:0] resp;
        rst_n        = 1'b0;
        play_button  = 1'b0;
        next_button  = 1'b0;
        axil_awaddr  = '0;
        axil_awvalid = 1'b0;
        axil_wdata   = '0;
        axil_wstrb   = '0;
        axil_wvalid  = 1'b0;
        axil_bready  = 1'b0;
        axil_araddr  = '0;
        axil_arvalid = 1'b0;
        axil_rready  = 1'b0;
        model_weight = weight_t'(`WEIGHT_DEFAULT);

        // Reset values, then registers with partial strobes and error cases
        add_step(OP_READ,  REG_CTRL,   0,            4'h0, `WEIGHT_DEFAULT, RESP_OKAY);
        add_step(OP_READ,  REG_BEAT,   0,            4'h0, `BEAT_DEFAULT,   RESP_OKAY);
        add_step(OP_WRITE, REG_CTRL,   32'h3,        4'hf, 0,               RESP_OKAY);
        add_step(OP_READ,  REG_CTRL,   0,            4'h0, 32'h3,           RESP_OKAY);
        add_step(OP_WRITE, REG_CTRL,   32'hffff_ff00, 4'he, 0,              RESP_OKAY);
        add_step(OP_READ,  REG_CTRL,   0,            4'h0, 32'h3,           RESP_OKAY);
        add_step(OP_WRITE, REG_BEAT,   32'h0012_3456, 4'h3, 0,              RESP_OKAY);
        add_step(OP_READ,  REG_BEAT,   0,            4'h0, 32'h3456,        RESP_OKAY);
        add_step(OP_WRITE, REG_BEAT,   32'h0077_0000, 4'h4, 0,              RESP_OKAY);
        add_step(OP_READ,  REG_BEAT,   0,            4'h0, 32'h77_3456,     RESP_OKAY);
        add_step(OP_WRITE, REG_BEAT,   0,            4'hf, 0,               RESP_OKAY);
        add_step(OP_READ,  REG_BEAT,   0,            4'h0, 32'h1,           RESP_OKAY);
        add_step(OP_WRITE, REG_STATUS, 32'hff,       4'hf, 0,               RESP_SLVERR);
        add_step(OP_READ,  REG_STATUS, 0,            4'h0, 0,               RESP_OKAY);
        add_step(OP_WRITE, 4'hc,       32'h1,        4'hf, 0,               RESP_SLVERR);
        add_step(OP_READ,  4'hc,       0,            4'h0, 0,               RESP_SLVERR);
        add_step(OP_WRITE, REG_BEAT,   32'h3e8,      4'h3, 0,               RESP_OKAY);
        add_step(OP_READ,  REG_BEAT,   0,            4'h0, 32'd1000,        RESP_OKAY);
        // Debounce, hold cycles and expected playing
        add_step(OP_PRESS, 4'h0, 3,  4'h0, 0, RESP_OKAY);
        add_step(OP_PRESS, 4'h0, 12, 4'h0, 1, RESP_OKAY);
        add_step(OP_PRESS, 4'h0, 12, 4'h0, 0, RESP_OKAY);
        // Song 0 at each weight, beat of 20
        add_step(OP_WRITE, REG_BEAT, 32'd20, 4'hf, 0, RESP_OKAY);
        for (int w = 0; w < 4; w++) begin
            add_step(OP_WRITE, REG_CTRL, w, 4'hf, 0, RESP_OKAY);
            add_step(OP_SONG, 4'h0, 32'd20, 4'h0, 0, RESP_OKAY);
        end
        // Next switches to song 1 and stops
        add_step(OP_NEXT, 4'h0, 32'd20, 4'h0, 0, RESP_OKAY);
        add_step(OP_READ, REG_STATUS, 0, 4'h0, 32'h2, RESP_OKAY);
        add_step(OP_SONG, 4'h1, 32'd20, 4'h0, 0, RESP_OKAY);
        add_step(OP_READ, REG_STATUS, 0, 4'h0, 32'h2, RESP_OKAY);

        total = 10;
        foreach (step_op[i])
            total += step_budget(step_op[i], step_data[i]);
        limit = 2 * total;

        repeat (2) @(posedge clk_100);
        #1 rst_n = 1'b1;
        @(negedge clk_100);
        check_value("playing", 32'(playing), 0);
        check_value("new_sample", 32'(new_sample), 0);
        check_value("sample", 32'(sample), 0);
        check_value("awready", 32'(axil_awready), 0);
        check_value("wready", 32'(axil_wready), 0);
        check_value("arready", 32'(axil_arready), 0);
        check_value("bvalid", 32'(axil_bvalid), 0);
        check_value("rvalid", 32'(axil_rvalid), 0);
        if (err_count == 0) begin
            tests_pass++;
            $display("test 0 reset: ok");
        end else begin
            tests_fail++;
            $display("test 0 reset: failed");
        end

        foreach (step_op[i]) begin
            errs_before = err_count;
            case (step_op[i])
                OP_WRITE: begin
                    axil_write(step_addr[i], step_data[i], step_strb[i], resp);
                    check_value("bresp", 32'(resp), 32'(step_resp[i]));
                end
                OP_READ: begin
                    axil_read(step_addr[i], rdata, resp);
                    check_value("rdata", rdata, step_exp[i]);
                    check_value("rresp", 32'(resp), 32'(step_resp[i]));
                end
                OP_PRESS: begin
                    press(0, int'(step_data[i]));
                    repeat (8) @(negedge clk_100);
                    check_value("playing", 32'(playing), step_exp[i]);
                end
                OP_SONG: follow_song(int'(step_addr[i]), int'(step_data[i]));
                default: next_during_play(int'(step_data[i]));
            endcase
            if (err_count == errs_before) begin
                tests_pass++;
                $display("test %0d %s: ok", i + 1, op_names[step_op[i]]);
            end else begin
                tests_fail++;
                $display("test %0d %s: failed", i + 1, op_names[step_op[i]]);
            end
        end

        $display("tests run: %0d, passed: %0d, failed: %0d",
                 tests_pass + tests_fail, tests_pass, tests_fail);
        if (tests_fail == 0 && err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: logic/music_player_top.sv
`timescale 1ns/1ps
`default_nettype none

module music_player_top #(
    parameter int BPU_WIDTH = 20
) (
    input  wire logic                  clk_100,
    input  wire logic                  rst_n,
    input  wire logic                  play_button,
    input  wire logic                  next_button,
    // Frame strobe from the codec
    input  wire logic                  new_frame,
    input  wire axil_pkg::axil_addr_t  axil_awaddr,
    input  wire logic                  axil_awvalid,
    output logic                       axil_awready,
    input  wire axil_pkg::axil_data_t  axil_wdata,
    input  wire axil_pkg::axil_strb_t  axil_wstrb,
    input  wire logic                  axil_wvalid,
    output logic                       axil_wready,
    output axil_pkg::axil_resp_t       axil_bresp,
    output logic                       axil_bvalid,
    input  wire logic                  axil_bready,
    input  wire axil_pkg::axil_addr_t  axil_araddr,
    input  wire logic                  axil_arvalid,
    output logic                       axil_arready,
    output axil_pkg::axil_data_t       axil_rdata,
    output axil_pkg::axil_resp_t       axil_rresp,
    output logic                       axil_rvalid,
    input  wire logic                  axil_rready,
    output player_pkg::sample_t        sample,
    output logic                       new_sample,
    output logic                       playing,
    output player_pkg::note_t          note
);
    import player_pkg::*;

    logic       play_pulse;
    logic       next_pulse;
    song_t      song;
    logic [2:0] note_addr;
    weight_t    weight;
    beat_t      beat_count;

    // ==================================================
    // Button pulses
    // ==================================================
    button_press_unit #(.WIDTH(BPU_WIDTH)) play_press (
        .clk(clk_100), .rst_n(rst_n), .in(play_button), .out(play_pulse)
    );

    button_press_unit #(.WIDTH(BPU_WIDTH)) next_press (
        .clk(clk_100), .rst_n(rst_n), .in(next_button), .out(next_pulse)
    );

    // Sequencer and tone source
    song_reader song_reader (
        .clk(clk_100), .rst_n(rst_n), .play(play_pulse), .next(next_pulse),
        .beat_count(beat_count), .note(note), .playing(playing),
        .song(song), .note_addr(note_addr)
    );

    note_gen note_gen (
        .clk(clk_100), .rst_n(rst_n), .new_frame(new_frame), .note(note),
        .weight(weight), .sample(sample), .new_sample(new_sample)
    );

    // Control and status registers
    player_regs player_regs (
        .clk(clk_100), .rst_n(rst_n),
        .axil_awaddr(axil_awaddr), .axil_awvalid(axil_awvalid), .axil_awready(axil_awready),
        .axil_wdata(axil_wdata), .axil_wstrb(axil_wstrb),
        .axil_wvalid(axil_wvalid), .axil_wready(axil_wready),
        .axil_bresp(axil_bresp), .axil_bvalid(axil_bvalid), .axil_bready(axil_bready),
        .axil_araddr(axil_araddr), .axil_arvalid(axil_arvalid), .axil_arready(axil_arready),
        .axil_rdata(axil_rdata), .axil_rresp(axil_rresp),
        .axil_rvalid(axil_rvalid), .axil_rready(axil_rready),
        .playing(playing), .song(song), .note_addr(note_addr),
        .weight(weight), .beat_count(beat_count)
    );

endmodule

`default_nettype wire

// File: player/player_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "player_params.svh"

module player_regs (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire axil_pkg::axil_addr_t  axil_awaddr,
    input  wire logic                  axil_awvalid,
    output logic                       axil_awready,
    input  wire axil_pkg::axil_data_t  axil_wdata,
    input  wire axil_pkg::axil_strb_t  axil_wstrb,
    input  wire logic                  axil_wvalid,
    output logic                       axil_wready,
    output axil_pkg::axil_resp_t       axil_bresp,
    output logic                       axil_bvalid,
    input  wire logic                  axil_bready,
    input  wire axil_pkg::axil_addr_t  axil_araddr,
    input  wire logic                  axil_arvalid,
    output logic                       axil_arready,
    output axil_pkg::axil_data_t       axil_rdata,
    output axil_pkg::axil_resp_t       axil_rresp,
    output logic                       axil_rvalid,
    input  wire logic                  axil_rready,
    input  wire logic                  playing,
    input  wire player_pkg::song_t     song,
    input  wire logic [2:0]            note_addr,
    output player_pkg::weight_t        weight,
    output player_pkg::beat_t          beat_count
);
    import axil_pkg::*;
    import player_pkg::*;

    // Halves of a write seen so far
    logic       aw_done;
    logic       w_done;
    axil_addr_t awaddr_q;
    axil_data_t wdata_q;
    axil_strb_t wstrb_q;
    logic       aw_hs;
    logic       w_hs;
    logic       wr_fire;
    logic       aw_done_n;
    logic       w_done_n;
    logic       bvalid_n;
    axil_addr_t wr_addr;
    axil_data_t wr_data;
    axil_strb_t wr_strb;
    axil_resp_t wr_resp;
    axil_data_t ctrl_merged;
    axil_data_t beat_merged;
    beat_t      beat_wr;
    logic       ar_hs;
    logic       rvalid_n;
    axil_data_t rd_data;
    axil_resp_t rd_resp;

    // Byte lanes from data where strobed
    function automatic axil_data_t apply_strb(axil_data_t old, axil_data_t data,
                                              axil_strb_t strb);
        axil_data_t merged;
        merged = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                merged[8*i +: 8] = data[8*i +: 8];
        end
        return merged;
    endfunction

    // ==================================================
    // Write channel
    // ==================================================
    always_comb begin
        aw_hs   = axil_awready && axil_awvalid;
        w_hs    = axil_wready && axil_wvalid;
        // Live channel when not yet latched
        wr_addr = aw_done ? awaddr_q : axil_awaddr;
        wr_data = w_done ? wdata_q : axil_wdata;
        wr_strb = w_done ? wstrb_q : axil_wstrb;
        // Both halves present, commit now
        wr_fire   = (aw_done || aw_hs) && (w_done || w_hs);
        aw_done_n = !wr_fire && (aw_done || aw_hs);
        w_done_n  = !wr_fire && (w_done || w_hs);
        bvalid_n  = wr_fire || (axil_bvalid && !axil_bready);

        ctrl_merged = apply_strb(32'(weight), wr_data, wr_strb);
        beat_merged = apply_strb(32'(beat_count), wr_data, wr_strb);
        // Zero beat would stall the song
        beat_wr = beat_merged[`BEAT_W-1:0];
        if (beat_wr == '0)
            beat_wr = 1;

        // Status is read only
        wr_resp = (wr_addr == REG_CTRL || wr_addr == REG_BEAT) ? RESP_OKAY : RESP_SLVERR;
    end

    // ==================================================
    // Read channel decode
    // ==================================================
    always_comb begin
        ar_hs    = axil_arready && axil_arvalid;
        rvalid_n = ar_hs || (axil_rvalid && !axil_rready);
        rd_resp  = RESP_OKAY;
        case (axil_araddr)
            REG_CTRL:   rd_data = 32'(weight);
            REG_BEAT:   rd_data = 32'(beat_count);
            REG_STATUS: rd_data = {25'b0, note_addr, 2'b0, song, playing};
            default: begin
                rd_data = '0;
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_done      <= 1'b0;
            w_done       <= 1'b0;
            axil_awready <= 1'b0;
            axil_wready  <= 1'b0;
            axil_bvalid  <= 1'b0;
            axil_arready <= 1'b0;
            axil_rvalid  <= 1'b0;
            weight       <= `WEIGHT_DEFAULT;
            beat_count   <= `BEAT_DEFAULT;
        end else begin
            aw_done     <= aw_done_n;
            w_done      <= w_done_n;
            axil_bvalid <= bvalid_n;
            // No new address or data while a response waits
            axil_awready <= !aw_done_n && !bvalid_n;
            axil_wready  <= !w_done_n && !bvalid_n;
            axil_rvalid  <= rvalid_n;
            axil_arready <= !rvalid_n;
            if (wr_fire) begin
                case (wr_addr)
                    REG_CTRL: weight     <= ctrl_merged[1:0];
                    REG_BEAT: beat_count <= beat_wr;
                    default: ;
                endcase
            end
        end
    end

    // Captured payload
    always_ff @(posedge clk) begin
        if (aw_hs)
            awaddr_q <= axil_awaddr;
        if (w_hs) begin
            wdata_q <= axil_wdata;
            wstrb_q <= axil_wstrb;
        end
        if (wr_fire)
            axil_bresp <= wr_resp;
        if (ar_hs) begin
            axil_rdata <= rd_data;
            axil_rresp <= rd_resp;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (axil_bvalid && !axil_bready) |=> axil_bvalid);

endmodule

`default_nettype wire

// File: player/note_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "player_params.svh"

module note_gen (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 new_frame,
    input  wire player_pkg::note_t    note,
    input  wire player_pkg::weight_t  weight,
    output player_pkg::sample_t       sample,
    output logic                      new_sample
);
    import player_pkg::*;

    localparam int PW = `PHASE_W;
    // Phase step per frame is note * 64
    localparam int STEP_SHIFT = 6;
    // Amplitude at weight 0
    localparam logic [`SAMPLE_W-1:0] BASE_AMP = 'h0FFF;

    logic [PW-1:0] phase;
    logic [PW-1:0] phase_base;
    logic [PW-1:0] phase_next;
    note_t   prev_note;
    sample_t amp;
    sample_t level;

    always_comb begin
        // Restart the waveform on a note change
        phase_base = (note != prev_note) ? '0 : phase;
        phase_next = phase_base + (PW'(note) << STEP_SHIFT);
        amp        = sample_t'(BASE_AMP << weight);
        // Square wave, sign from phase MSB
        if (note == '0)
            level = '0;
        else if (phase_next[PW-1])
            level = -amp;
        else
            level = amp;
    end

    // ==================================================
    // Phase accumulator and sample register
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= '0;
            prev_note  <= '0;
            sample     <= '0;
            new_sample <= 1'b0;
        end else begin
            prev_note  <= note;
            new_sample <= new_frame;
            if (new_frame) begin
                phase  <= phase_next;
                sample <= level;
            end else begin
                phase <= phase_base;
            end
        end
    end

    // Samples only follow a codec frame strobe
    a_sample_after_frame: assert property (@(posedge clk) disable iff (!rst_n)
        new_sample |-> $past(new_frame));

endmodule

`default_nettype wire

// File: player/song_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "player_params.svh"

module song_reader (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                play,
    input  wire logic                next,
    input  wire player_pkg::beat_t   beat_count,
    output player_pkg::note_t        note,
    output logic                     playing,
    output player_pkg::song_t        song,
    output logic [2:0]               note_addr
);
    import player_pkg::*;

    note_t rom_note;
    beat_t beat_cnt;
    logic  beat_end;
    logic  last_note;

    // ==================================================
    // Note ROM, song in the top address bit
    // ==================================================
    always_comb begin
        case ({song, note_addr})
            // Song 0, rising line with a rest
            4'h0: rom_note = 6'd20;
            4'h1: rom_note = 6'd22;
            4'h2: rom_note = 6'd24;
            4'h3: rom_note = 6'd0;
            4'h4: rom_note = 6'd25;
            4'h5: rom_note = 6'd27;
            4'h6: rom_note = 6'd29;
            4'h7: rom_note = 6'd32;
            // Song 1, falling line
            4'h8: rom_note = 6'd40;
            4'h9: rom_note = 6'd37;
            4'ha: rom_note = 6'd0;
            4'hb: rom_note = 6'd35;
            4'hc: rom_note = 6'd33;
            4'hd: rom_note = 6'd30;
            4'he: rom_note = 6'd28;
            default: rom_note = 6'd25;
        endcase
    end

    // Silent whenever stopped
    assign note = playing ? rom_note : '0;

    // Reaching beat_count - 1 ends the note
    assign beat_end  = (beat_cnt >= beat_count - 1'b1);
    assign last_note = (note_addr == 3'(`SONG_LEN - 1));

    // ==================================================
    // Play, next and beat sequencing
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            playing   <= 1'b0;
            song      <= 1'b0;
            note_addr <= '0;
            beat_cnt  <= '0;
        end else if (next) begin
            // Other song, stopped at its start
            song      <= ~song;
            note_addr <= '0;
            playing   <= 1'b0;
            beat_cnt  <= '0;
        end else if (play) begin
            playing <= ~playing;
            // Fresh beat on start
            if (!playing)
                beat_cnt <= '0;
        end else if (playing) begin
            if (beat_end) begin
                beat_cnt <= '0;
                if (last_note) begin
                    // End of song
                    playing   <= 1'b0;
                    note_addr <= '0;
                end else begin
                    note_addr <= note_addr + 1'b1;
                end
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(note_addr) < `SONG_LEN);

endmodule

`default_nettype wire

// File: logic/button_press_unit.sv
`timescale 1ns/1ps
`default_nettype none

module button_press_unit #(
    parameter int WIDTH = 20
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic in,
    output logic      out
);

    // Two-flop synchronizer
    logic sync_meta;
    logic sync_in;
    // Consecutive-high count, saturates at all ones
    logic [WIDTH-1:0] stable_cnt;
    // This press already gave its pulse
    logic fired;
    logic stable;

    // High for 2^WIDTH cycles in a row
    assign stable = sync_in && (stable_cnt == {WIDTH{1'b1}});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta  <= 1'b0;
            sync_in    <= 1'b0;
            stable_cnt <= '0;
            fired      <= 1'b0;
            out        <= 1'b0;
        end else begin
            sync_meta <= in;
            sync_in   <= sync_meta;
            // Single pulse, then wait for release
            out <= stable && !fired;
            if (!sync_in) begin
                stable_cnt <= '0;
                fired      <= 1'b0;
            end else if (!stable) begin
                stable_cnt <= stable_cnt + 1'b1;
            end else begin
                fired <= 1'b1;
            end
        end
    end

    // One pulse per press, never a two-cycle pulse
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n) out |=> !out);

endmodule

`default_nettype wire

// File: common/axil_pkg.sv
`default_nettype none

package axil_pkg;

    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // Register map, byte offsets
    localparam axil_addr_t REG_CTRL   = 4'h0;
    localparam axil_addr_t REG_BEAT   = 4'h4;
    localparam axil_addr_t REG_STATUS = 4'h8;

endpackage

`default_nettype wire

// File: common/player_pkg.sv
`default_nettype none

`include "player_params.svh"

package player_pkg;

    // Note index into the tone table, zero is a rest
    typedef logic [`NOTE_W-1:0] note_t;

    // Signed audio sample as sent toward the codec
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // Volume weight, a left shift of the base amplitude
    typedef logic [1:0] weight_t;

    // Song select, two songs in the ROM
    typedef logic song_t;

    // Clock cycles per note
    typedef logic [`BEAT_W-1:0] beat_t;

endpackage

`default_nettype wire

// File: common/player_params.svh
`ifndef PLAYER_PARAMS_SVH
`define PLAYER_PARAMS_SVH

// ==================================================
// Audio datapath widths
// ==================================================
`define SAMPLE_W 16
`define PHASE_W 20
`define NOTE_W 6

// ==================================================
// Song and register sizing
// ==================================================
`define SONG_LEN 8
`define BEAT_W 24
// Cycles per note out of reset
`define BEAT_DEFAULT 1000
`define WEIGHT_DEFAULT 2

`endif
